// ==== spio_link_defs.svh ====
/*
 * SpiNNaker 2-of-7 link constants
 * Symbol width, packet lengths in nibbles and synchronizer depth
 */

`ifndef SPIO_LINK_DEFS_SVH
`define SPIO_LINK_DEFS_SVH

// Number of data wires in each link direction
`define SPIO_SYM_W 7

// Bits carried by one data symbol
`define SPIO_NIB_W 4

// Data symbols before end-of-packet
// Header and key only
`define SPIO_SHORT_NIBBLES 10
// Header, key and payload
`define SPIO_LONG_NIBBLES 18

// Nibble counter width, must hold SPIO_LONG_NIBBLES
`define SPIO_NIB_CNT_W 5

// Flip-flops in each input synchronizer chain
`define SPIO_SYNC_STAGES 2

`endif

// ==== spio_pkt_pkg.sv ====
/*
 * SpiNNaker packet types
 * Header layout and the 72-bit packet as it moves over the link
 */

`default_nettype none

package spio_pkt_pkg;

	////////////////////
	// Packet header
	////////////////////

	// Parity sits in bit 0 and covers every transmitted bit
	// Total count of ones must be odd for a good packet
	typedef struct packed {
		// Routing and type bits, passed through untouched
		logic [5:0] ctrl;
		// Set when a 32-bit payload follows the key
		logic       payload_present;
		// Odd parity over header, key and payload
		logic       parity;
	} header_t;

	////////////////////
	// Whole packet
	////////////////////

	// Header in the low byte so that LSB-first nibble order
	// matches the order of symbols on the wires
	typedef struct packed {
		logic [31:0] payload;
		logic [31:0] key;
		header_t     header;
	} packet_t;

endpackage

`default_nettype wire

// ==== spio_sym_pkg.sv ====
/*
 * SpiNNaker 2-of-7 symbol coding and link FSM states
 * Code table, decode result type and nibble conversion functions
 */

`default_nettype none

`include "spio_link_defs.svh"

package spio_sym_pkg;

	// Each code is the mask of the two wires that toggle
	typedef enum logic [`SPIO_SYM_W-1:0] {
		NIB_0  = 7'b0010001, NIB_1  = 7'b0010010,
		NIB_2  = 7'b0010100, NIB_3  = 7'b0011000,
		NIB_4  = 7'b0100001, NIB_5  = 7'b0100010,
		NIB_6  = 7'b0100100, NIB_7  = 7'b0101000,
		NIB_8  = 7'b1000001, NIB_9  = 7'b1000010,
		NIB_10 = 7'b1000100, NIB_11 = 7'b1001000,
		NIB_12 = 7'b0000011, NIB_13 = 7'b0000110,
		NIB_14 = 7'b0001100, NIB_15 = 7'b0001001,
		// Wires 6 and 5 mark the end of a packet
		EOP    = 7'b1100000
	} sym_t;

	// Outcome of decoding one two-wire transition
	typedef struct packed {
		logic                  is_nib;
		logic                  is_eop;
		logic [`SPIO_NIB_W-1:0] nib;
	} sym_dec_t;

	typedef enum logic [1:0] {TX_IDLE, TX_SYMBOL, TX_WAIT_ACK, TX_EOP_WAIT} tx_state_t;

	typedef enum logic [1:0] {RX_COLLECT, RX_ACK, RX_DISCARD} rx_state_t;

	// Nibble to wire mask
	// Nibble value is the position in the enum
	function automatic sym_t nib_to_sym(input logic [`SPIO_NIB_W-1:0] nib);
		sym_t code;
		// Step through the table to reach the wanted entry
		code = NIB_0;
		for (int n = 0; n < 16; n++)
		begin
			if (n < int'(nib))
				code = code.next();
		end
		return code;
	endfunction

	// Wire mask to nibble
	// Any other two-wire mask is neither nibble nor EOP
	function automatic sym_dec_t sym_to_nib(input logic [`SPIO_SYM_W-1:0] mask);
		sym_dec_t dec;
		dec = '0;
		if (mask == EOP)
			dec.is_eop = 1'b1;
		for (int n = 0; n < 16; n++)
		begin
			if (mask == nib_to_sym(n[`SPIO_NIB_W-1:0]))
			begin
				dec.is_nib = 1'b1;
				dec.nib    = n[`SPIO_NIB_W-1:0];
			end
		end
		return dec;
	endfunction

endpackage

`default_nettype wire

// ==== spio_link_sender.sv ====
/*
 * SpiNNaker link sender
 * Turns one packet into NRZ 2-of-7 symbols, one per remote acknowledge,
 * and closes it with end-of-packet
 */

`timescale 1ns/1ps
`default_nettype none

`include "spio_link_defs.svh"

module spio_link_sender (
	input  wire logic                  clk_i,
	input  wire logic                  reset_i,
	// Packet source
	input  wire spio_pkt_pkg::packet_t tx_pkt_i,
	input  wire logic                  tx_vld_i,
	output logic                       tx_rdy_o,
	// Outgoing link wires
	output logic [`SPIO_SYM_W-1:0]     sl_out_data_o,
	input  wire logic                  sl_out_ack_i
);

	spio_sym_pkg::tx_state_t state_q;

	// Packet being sent, shifted down one nibble per symbol
	logic [$bits(spio_pkt_pkg::packet_t)-1:0] tx_shift_q;

	// Symbols sent so far and the length of this packet
	logic [`SPIO_NIB_CNT_W-1:0] nib_cnt_q;
	logic [`SPIO_NIB_CNT_W-1:0] nib_end;
	logic                       long_q;

	// Acknowledge synchronizer and last seen level
	logic [`SPIO_SYNC_STAGES-1:0] ack_sync_q;
	logic                         ack_seen_q;
	logic                         ack_edge;

	////////////////////
	// Flow control
	////////////////////

	// New packet only between packets
	assign tx_rdy_o = (state_q == spio_sym_pkg::TX_IDLE);

	// Ack is NRZ so any level change counts
	assign ack_edge = ack_sync_q[`SPIO_SYNC_STAGES-1] ^ ack_seen_q;

	assign nib_end = long_q ? `SPIO_NIB_CNT_W'(`SPIO_LONG_NIBBLES)
	                        : `SPIO_NIB_CNT_W'(`SPIO_SHORT_NIBBLES);

	////////////////////
	// Symbol FSM
	////////////////////

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state_q       <= spio_sym_pkg::TX_IDLE;
			nib_cnt_q     <= '0;
			long_q        <= 1'b0;
			ack_sync_q    <= '0;
			ack_seen_q    <= 1'b0;
			sl_out_data_o <= '0;
		end
		else
		begin
			// Ack crosses in from the remote end
			ack_sync_q <= {ack_sync_q[`SPIO_SYNC_STAGES-2:0], sl_out_ack_i};
			ack_seen_q <= ack_sync_q[`SPIO_SYNC_STAGES-1];

			case (state_q)
				spio_sym_pkg::TX_IDLE:
					if (tx_vld_i)
					begin
						state_q   <= spio_sym_pkg::TX_SYMBOL;
						nib_cnt_q <= '0;
						long_q    <= tx_pkt_i.header.payload_present;
					end
				spio_sym_pkg::TX_SYMBOL:
					// All nibbles out, so close the packet
					if (nib_cnt_q == nib_end)
					begin
						sl_out_data_o <= sl_out_data_o ^ spio_sym_pkg::EOP;
						state_q       <= spio_sym_pkg::TX_EOP_WAIT;
					end
					else
					begin
						sl_out_data_o <= sl_out_data_o
						                 ^ spio_sym_pkg::nib_to_sym(tx_shift_q[`SPIO_NIB_W-1:0]);
						nib_cnt_q     <= nib_cnt_q + 1'b1;
						state_q       <= spio_sym_pkg::TX_WAIT_ACK;
					end
				spio_sym_pkg::TX_WAIT_ACK:
					if (ack_edge)
						state_q <= spio_sym_pkg::TX_SYMBOL;
				spio_sym_pkg::TX_EOP_WAIT:
					// Remote has taken the whole packet
					if (ack_edge)
						state_q <= spio_sym_pkg::TX_IDLE;
				default:
					state_q <= spio_sym_pkg::TX_IDLE;
			endcase
		end
	end

	// Packet shift register, LSB nibble goes first
	always_ff @(posedge clk_i)
	begin
		if (tx_rdy_o && tx_vld_i)
			tx_shift_q <= tx_pkt_i;
		else if ((state_q == spio_sym_pkg::TX_SYMBOL) && (nib_cnt_q != nib_end))
			tx_shift_q <= tx_shift_q >> `SPIO_NIB_W;
	end

endmodule

`default_nettype wire

// ==== spio_link_receiver.sv ====
/*
 * SpiNNaker link receiver
 * Decodes incoming 2-of-7 transitions, acknowledges each symbol,
 * rebuilds the packet and flags parity and framing faults
 */

`timescale 1ns/1ps
`default_nettype none

`include "spio_link_defs.svh"

module spio_link_receiver (
	input  wire logic               clk_i,
	input  wire logic               reset_i,
	// Incoming link wires
	input  wire logic [`SPIO_SYM_W-1:0] sl_in_data_i,
	output logic                    sl_in_ack_o,
	// Packet sink, no back-pressure
	output spio_pkt_pkg::packet_t   rx_pkt_o,
	output logic                    rx_vld_o,
	output logic                    rx_parity_err_o,
	output logic                    rx_frame_err_o
);

	// Input synchronizer, last stage is the usable view of the wires
	logic [`SPIO_SYNC_STAGES-1:0][`SPIO_SYM_W-1:0] sync_q;
	// Wire levels at the last accepted symbol
	logic [`SPIO_SYM_W-1:0] line_q;
	logic [`SPIO_SYM_W-1:0] diff;

	logic                   sym_det;
	spio_sym_pkg::sym_dec_t dec;

	spio_sym_pkg::rx_state_t state_q;
	// Where to go once the ack has been sent
	spio_sym_pkg::rx_state_t resume_q;

	logic [`SPIO_NIB_CNT_W-1:0] nib_cnt_q;
	spio_pkt_pkg::packet_t      asm_q;
	spio_pkt_pkg::packet_t      rx_view;
	logic                       len_ok;
	logic                       nib_take;

	// Results held for the ack cycle
	logic done_q;
	logic ferr_q;

	////////////////////
	// Symbol detection
	////////////////////

	assign diff = sync_q[`SPIO_SYNC_STAGES-1] ^ line_q;

	// Exactly two wires moved, anything less is still in flight
	assign sym_det = (state_q != spio_sym_pkg::RX_ACK) && ($countones(diff) == 2);
	assign dec     = spio_sym_pkg::sym_to_nib(diff);

	// A data nibble that still fits in a long packet
	assign nib_take = dec.is_nib && (nib_cnt_q != `SPIO_NIB_CNT_W'(`SPIO_LONG_NIBBLES));

	always_comb
	begin
		rx_view = asm_q;
		// Short packet carries no payload, leftovers from older packets are hidden
		if (!asm_q.header.payload_present)
			rx_view.payload = '0;
		len_ok = asm_q.header.payload_present
		         ? (nib_cnt_q == `SPIO_NIB_CNT_W'(`SPIO_LONG_NIBBLES))
		         : (nib_cnt_q == `SPIO_NIB_CNT_W'(`SPIO_SHORT_NIBBLES));
	end

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
			sync_q <= '0;
		else
			sync_q <= {sync_q[`SPIO_SYNC_STAGES-2:0], sl_in_data_i};
	end

	////////////////////
	// Receive FSM
	////////////////////

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state_q        <= spio_sym_pkg::RX_COLLECT;
			resume_q       <= spio_sym_pkg::RX_COLLECT;
			line_q         <= '0;
			nib_cnt_q      <= '0;
			done_q         <= 1'b0;
			ferr_q         <= 1'b0;
			sl_in_ack_o    <= 1'b0;
			rx_vld_o       <= 1'b0;
			rx_frame_err_o <= 1'b0;
		end
		else
		begin
			rx_vld_o       <= 1'b0;
			rx_frame_err_o <= 1'b0;
			case (state_q)
				spio_sym_pkg::RX_COLLECT:
					if (sym_det)
					begin
						line_q   <= sync_q[`SPIO_SYNC_STAGES-1];
						state_q  <= spio_sym_pkg::RX_ACK;
						resume_q <= spio_sym_pkg::RX_COLLECT;
						done_q   <= 1'b0;
						ferr_q   <= 1'b0;
						if (dec.is_eop)
						begin
							// Length must match the payload-present bit
							nib_cnt_q <= '0;
							done_q    <= len_ok;
							ferr_q    <= !len_ok;
						end
						else if (nib_take)
							nib_cnt_q <= nib_cnt_q + 1'b1;
						else
						begin
							// Overlong or bad code, drop up to the next EOP
							nib_cnt_q <= '0;
							ferr_q    <= 1'b1;
							resume_q  <= spio_sym_pkg::RX_DISCARD;
						end
					end
				spio_sym_pkg::RX_DISCARD:
					if (sym_det)
					begin
						line_q   <= sync_q[`SPIO_SYNC_STAGES-1];
						state_q  <= spio_sym_pkg::RX_ACK;
						done_q   <= 1'b0;
						ferr_q   <= 1'b0;
						resume_q <= dec.is_eop ? spio_sym_pkg::RX_COLLECT
						                       : spio_sym_pkg::RX_DISCARD;
					end
				spio_sym_pkg::RX_ACK:
				begin
					// One ack transition per symbol
					sl_in_ack_o    <= ~sl_in_ack_o;
					rx_vld_o       <= done_q;
					rx_frame_err_o <= ferr_q;
					state_q        <= resume_q;
				end
				default:
					state_q <= spio_sym_pkg::RX_COLLECT;
			endcase
		end
	end

	// Assembly and output registers
	always_ff @(posedge clk_i)
	begin
		if ((state_q == spio_sym_pkg::RX_COLLECT) && sym_det)
		begin
			if (nib_take)
				asm_q[{nib_cnt_q, 2'b00} +: `SPIO_NIB_W] <= dec.nib;
			if (dec.is_eop && len_ok)
			begin
				rx_pkt_o        <= rx_view;
				// Even count of ones means a bad parity bit
				rx_parity_err_o <= ~^rx_view;
			end
		end
	end

endmodule

`default_nettype wire

// ==== spio_link_top.sv ====
/*
 * SpiNNaker link endpoint
 * Independent sender and receiver on separate wire sets
 */

`timescale 1ns/1ps
`default_nettype none

`include "spio_link_defs.svh"

module spio_link_top (
	input  wire logic                   clk_i,
	input  wire logic                   reset_i,
	// Packets to send
	input  wire spio_pkt_pkg::packet_t  tx_pkt_i,
	input  wire logic                   tx_vld_i,
	output logic                        tx_rdy_o,
	// Outgoing link
	output logic [`SPIO_SYM_W-1:0]      sl_out_data_o,
	input  wire logic                   sl_out_ack_i,
	// Incoming link
	input  wire logic [`SPIO_SYM_W-1:0] sl_in_data_i,
	output logic                        sl_in_ack_o,
	// Received packets
	output spio_pkt_pkg::packet_t       rx_pkt_o,
	output logic                        rx_vld_o,
	output logic                        rx_parity_err_o,
	output logic                        rx_frame_err_o
);

	////////////////////
	// Outgoing half
	////////////////////

	spio_link_sender spio_link_sender_i (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.tx_pkt_i      (tx_pkt_i),
		.tx_vld_i      (tx_vld_i),
		.tx_rdy_o      (tx_rdy_o),
		.sl_out_data_o (sl_out_data_o),
		.sl_out_ack_i  (sl_out_ack_i)
	);

	////////////////////
	// Incoming half
	////////////////////

	spio_link_receiver spio_link_receiver_i (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.sl_in_data_i    (sl_in_data_i),
		.sl_in_ack_o     (sl_in_ack_o),
		.rx_pkt_o        (rx_pkt_o),
		.rx_vld_o        (rx_vld_o),
		.rx_parity_err_o (rx_parity_err_o),
		.rx_frame_err_o  (rx_frame_err_o)
	);

endmodule

`default_nettype wire

// ==== spio_link_tb.sv ====
/*
 * SpiNNaker link testbench
 * Loop-back and raw 2-of-7 symbol injection against a reference packet queue
 */

`timescale 1ns/1ps
`default_nettype none

`include "spio_link_defs.svh"

module spio_link_tb;

	logic                          clk_i;
	logic                          reset_i;
	spio_pkt_pkg::packet_t         tx_pkt_i;
	logic                          tx_vld_i;
	logic                          tx_rdy_o;
	logic [`SPIO_SYM_W-1:0]        sl_out_data_o;
	wire logic                     sl_out_ack_i;
	wire logic [`SPIO_SYM_W-1:0]   sl_in_data_i;
	logic                          sl_in_ack_o;
	spio_pkt_pkg::packet_t         rx_pkt_o;
	logic                          rx_vld_o;
	logic                          rx_parity_err_o;
	logic                          rx_frame_err_o;

	// Link source select
	logic                   inject_mode;
	// Raw wire state for inject mode
	logic [`SPIO_SYM_W-1:0] inj_data;

	// Packets in flight with the oldest first
	spio_pkt_pkg::packet_t ref_q[$];
	spio_pkt_pkg::packet_t exp_pkt;
	spio_pkt_pkg::packet_t pkt;

	integer seed;
	int     err_cnt;
	int     err_mark;
	int     test_cnt;
	int     test_fail_cnt;
	int     rx_cnt;
	int     perr_cnt;
	int     frame_exp;
	int     mark;

	assign sl_in_data_i = inject_mode ? inj_data : sl_out_data_o;
	// Remote acknowledge comes straight from our own receiver
	assign sl_out_ack_i = sl_in_ack_o;

	spio_link_top spio_link_top_i (
		.clk_i           (clk_i),
		.reset_i         (reset_i),
		.tx_pkt_i        (tx_pkt_i),
		.tx_vld_i        (tx_vld_i),
		.tx_rdy_o        (tx_rdy_o),
		.sl_out_data_o   (sl_out_data_o),
		.sl_out_ack_i    (sl_out_ack_i),
		.sl_in_data_i    (sl_in_data_i),
		.sl_in_ack_o     (sl_in_ack_o),
		.rx_pkt_o        (rx_pkt_o),
		.rx_vld_o        (rx_vld_o),
		.rx_parity_err_o (rx_parity_err_o),
		.rx_frame_err_o  (rx_frame_err_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] got,
	                               input logic [31:0] exp);
		$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
		err_cnt++;
	endtask

	task automatic report_problem(input string msg);
		$display("Error: %s", msg);
		err_cnt++;
	endtask

	// Odd count of ones over the bits that go on the wires
	function automatic logic parity_ok(input spio_pkt_pkg::packet_t p);
		logic [71:0] bits;
		int          n_bits;
		int          ones;
		bits   = p;
		n_bits = p.header.payload_present ? 72 : 40;
		ones   = 0;
		for (int b = 0; b < 72; b++)
		begin
			if (b < n_bits && bits[b])
				ones++;
		end
		return (ones % 2) == 1;
	endfunction

	task automatic build_pkt(input logic is_long, input logic good,
	                         output spio_pkt_pkg::packet_t p);
		logic [31:0] r;
		r                         = $random(seed);
		p.header.ctrl             = r[5:0];
		p.header.payload_present  = is_long;
		p.header.parity           = 1'b0;
		p.key                     = $random(seed);
		p.payload                 = $random(seed);
		// Set the parity bit so that the rule gives the wanted result
		p.header.parity           = (parity_ok(p) != good);
	endtask

	task automatic begin_test();
		err_mark = err_cnt;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		if (err_cnt == err_mark)
			$display("test %0d %s: passed", test_cnt, name);
		else
		begin
			test_fail_cnt++;
			$display("test %0d %s: failed", test_cnt, name);
		end
	endtask

	// Hand one packet to the sender once it is idle
	task automatic send_pkt(input spio_pkt_pkg::packet_t p);
		int cyc;
		cyc = 0;
		@(negedge clk_i);
		while (!tx_rdy_o && cyc < 1000)
		begin
			@(negedge clk_i);
			cyc++;
		end
		if (!tx_rdy_o)
			report_problem("sender never raised tx_rdy_o");
		else
		begin
			tx_pkt_i = p;
			tx_vld_i = 1'b1;
			ref_q.push_back(p);
			@(negedge clk_i);
			tx_vld_i = 1'b0;
		end
	endtask

	// Sender back in idle so its wires hold still
	task automatic wait_sender_idle(input int limit);
		int cyc;
		cyc = 0;
		@(negedge clk_i);
		while (!tx_rdy_o && cyc < limit)
		begin
			@(negedge clk_i);
			cyc++;
		end
		if (!tx_rdy_o)
			report_problem("sender did not return to idle");
	endtask

	// All expected packets and framing errors seen
	task automatic wait_drained(input int limit);
		int cyc;
		cyc = 0;
		while ((ref_q.size() != 0 || frame_exp != 0) && cyc < limit)
		begin
			@(negedge clk_i);
			cyc++;
		end
		if (ref_q.size() != 0 || frame_exp != 0)
		begin
			report_problem("receiver did not deliver everything in time");
			ref_q.delete();
			frame_exp = 0;
		end
	endtask

	// Toggle two wires, then wait for the receiver to answer
	task automatic inject_symbol(input logic [`SPIO_SYM_W-1:0] mask);
		logic prev;
		int   cyc;
		@(negedge clk_i);
		prev     = sl_in_ack_o;
		inj_data = inj_data ^ mask;
		cyc      = 0;
		while (sl_in_ack_o == prev && cyc < 40)
		begin
			@(negedge clk_i);
			cyc++;
		end
		if (sl_in_ack_o == prev)
			report_problem("no acknowledge for an injected symbol");
	endtask

	task automatic inject_pkt(input spio_pkt_pkg::packet_t p, input int n_nib);
		logic [71:0] bits;
		bits = p;
		for (int i = 0; i < n_nib; i++)
			inject_symbol(spio_sym_pkg::nib_to_sym(bits[i*`SPIO_NIB_W +: `SPIO_NIB_W]));
		inject_symbol(spio_sym_pkg::EOP);
	endtask

	////////////////////
	// Receive checks
	////////////////////

	always @(negedge clk_i)
	begin
		if (!reset_i && rx_vld_o)
		begin
			rx_cnt++;
			assert (ref_q.size() != 0)
			else
				report_problem("rx_vld_o pulsed with no packet outstanding");
			if (ref_q.size() != 0)
			begin
				exp_pkt = ref_q.pop_front();
				assert (rx_pkt_o.header == exp_pkt.header)
				else
					report_mismatch("rx_pkt_o.header", {24'h0, rx_pkt_o.header},
					                {24'h0, exp_pkt.header});
				assert (rx_pkt_o.key == exp_pkt.key)
				else
					report_mismatch("rx_pkt_o.key", rx_pkt_o.key, exp_pkt.key);
				// Payload only travels in long packets
				if (exp_pkt.header.payload_present)
				begin
					assert (rx_pkt_o.payload == exp_pkt.payload)
					else
						report_mismatch("rx_pkt_o.payload", rx_pkt_o.payload,
						                exp_pkt.payload);
				end
				assert (rx_parity_err_o == !parity_ok(exp_pkt))
				else
					report_mismatch("rx_parity_err_o", {31'h0, rx_parity_err_o},
					                {31'h0, !parity_ok(exp_pkt)});
				if (rx_parity_err_o)
					perr_cnt++;
			end
		end
		if (!reset_i && rx_frame_err_o)
		begin
			assert (frame_exp != 0)
			else
				report_problem("rx_frame_err_o pulsed on a well formed packet");
			if (frame_exp != 0)
				frame_exp--;
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial
	begin
		seed          = 32'h234;
		reset_i       = 1'b1;
		tx_pkt_i      = '0;
		tx_vld_i      = 1'b0;
		inject_mode   = 1'b0;
		inj_data      = '0;
		err_cnt       = 0;
		err_mark      = 0;
		test_cnt      = 0;
		test_fail_cnt = 0;
		rx_cnt        = 0;
		perr_cnt      = 0;
		frame_exp     = 0;
		repeat (2) @(posedge clk_i);
		@(negedge clk_i);
		reset_i = 1'b0;

		// Idle levels straight out of reset
		begin_test();
		@(negedge clk_i);
		assert (tx_rdy_o == 1'b1)
		else
			report_mismatch("tx_rdy_o", {31'h0, tx_rdy_o}, 32'h1);
		assert (sl_out_data_o == '0)
		else
			report_mismatch("sl_out_data_o", {25'h0, sl_out_data_o}, 32'h0);
		assert (sl_in_ack_o == 1'b0)
		else
			report_mismatch("sl_in_ack_o", {31'h0, sl_in_ack_o}, 32'h0);
		end_test("reset state");

		begin_test();
		for (int i = 0; i < 4; i++)
		begin
			build_pkt(1'b0, 1'b1, pkt);
			send_pkt(pkt);
			wait_drained(1000);
		end
		end_test("short loop-back");

		// Back-to-back sends paced by tx_rdy_o
		begin_test();
		for (int i = 0; i < 4; i++)
		begin
			build_pkt(1'b1, 1'b1, pkt);
			send_pkt(pkt);
		end
		wait_drained(2000);
		end_test("long loop-back");

		begin_test();
		mark = perr_cnt;
		build_pkt(1'b0, 1'b0, pkt);
		send_pkt(pkt);
		build_pkt(1'b1, 1'b0, pkt);
		send_pkt(pkt);
		wait_drained(2000);
		assert (perr_cnt == mark + 2)
		else
			report_problem("bad parity packets were not flagged");
		end_test("parity error");

		// Hand the wires over once the sender is idle
		begin_test();
		wait_sender_idle(100);
		inj_data    = sl_out_data_o;
		inject_mode = 1'b1;
		mark        = rx_cnt;
		frame_exp   = 1;
		build_pkt(1'b0, 1'b1, pkt);
		inject_pkt(pkt, 6);
		wait_drained(200);
		assert (rx_cnt == mark)
		else
			report_problem("a cut packet was delivered");
		end_test("framing error");

		begin_test();
		build_pkt(1'b0, 1'b1, pkt);
		ref_q.push_back(pkt);
		inject_pkt(pkt, `SPIO_SHORT_NIBBLES);
		wait_drained(200);
		end_test("recovery");

		$display("tests %0d, failed tests %0d, errors %0d, packets received %0d",
		         test_cnt, test_fail_cnt, err_cnt, rx_cnt);
		if (err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
spio_pkt_pkg.sv
spio_sym_pkg.sv
spio_link_sender.sv
spio_link_receiver.sv
spio_link_top.sv
spio_link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the SpiNNaker link testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=spio_link_tb
BIN=spio_link_sim

verilator --binary --timing --assert \
	-f sources.f \
	--top-module "$TOP" \
	-Mdir obj_dir \
	-o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if [ ! -s "$LOG" ]; then
	echo "Simulation log is empty"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation passed"
exit 0
